// File: mem_pkg.sv
package mem_pkg;

    localparam int ADDR_W         = 16;
    localparam int WORD_W         = 32;
    localparam int LINE_BYTES     = 16;
    localparam int LINE_W         = LINE_BYTES * 8;
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;
    localparam int MEM_BYTES      = 65536;
    localparam int INDEX_W        = 4;
    localparam int NUM_LINES      = 2 ** INDEX_W;
    localparam int OFFSET_W       = 4;
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
    localparam int MEM_LATENCY    = 10;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } data_type_e;

    typedef struct packed {
        logic              is_store;
        data_type_e        dtype;
        logic              is_unsigned;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } core_req_t;

    typedef struct packed {
        data_type_e        dtype;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } mem_wr_t;

    // a line is indexed per byte for stores and sub-word loads, per word otherwise.
    typedef union packed {
        logic [LINE_BYTES-1:0][7:0]         bytes;
        logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;
    } line_u;

    function automatic logic [2:0] access_bytes(input data_type_e dtype);
        case (dtype)
            BYTE:    return 3'd1;
            HALF:    return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

endpackage

// File: main_memory.sv
`timescale 1ns/1ps

module main_memory (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             rd_i,
    input  logic [mem_pkg::ADDR_W-1:0] rd_addr_i,
    input  logic             wr_i,
    input  mem_pkg::mem_wr_t wr_i_data_i,
    output logic             data_rdy_o,
    output mem_pkg::line_u   data_o
);

    localparam int LAT = mem_pkg::MEM_LATENCY;

    logic [7:0] mem [mem_pkg::MEM_BYTES] = '{default: '0};

    logic [LAT-1:0]                rd_vld_q;
    logic [mem_pkg::ADDR_W-1:0]    rd_addr_q [LAT];
    logic [2:0]                    wr_bytes;
    logic [mem_pkg::ADDR_W-1:0]    out_base;

    assign wr_bytes = mem_pkg::access_bytes(wr_i_data_i.dtype);

    // stores are little endian, low byte at the lowest address.
    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            for (int i = 0; i < 4; i++) begin
                if (3'(i) < wr_bytes) begin
                    mem[wr_i_data_i.addr + mem_pkg::ADDR_W'(i)] <=
                        wr_i_data_i.wdata[8*i +: 8];
                end
            end
        end
    end

    // one read can enter the pipe every cycle.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_vld_q <= '0;
        end else begin
            rd_vld_q <= {rd_vld_q[LAT-2:0], rd_i};
        end
    end

    always_ff @(posedge clk_i) begin
        rd_addr_q[0] <= rd_addr_i;
        for (int s = 1; s < LAT; s++) begin
            rd_addr_q[s] <= rd_addr_q[s-1];
        end
    end

    assign data_rdy_o = rd_vld_q[LAT-1];

    // the line is taken from the array in the cycle the ready pulse is high.
    assign out_base = {rd_addr_q[LAT-1][mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W],
                       {mem_pkg::OFFSET_W{1'b0}}};

    always_comb begin
        for (int i = 0; i < mem_pkg::LINE_BYTES; i++) begin
            data_o.bytes[i] = mem[out_base + mem_pkg::ADDR_W'(i)];
        end
    end

endmodule

// File: dcache_array.sv
`timescale 1ns/1ps

module dcache_array (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic [mem_pkg::ADDR_W-1:0] lookup_addr_i,
    output logic                       hit_o,
    output mem_pkg::line_u             line_o,
    input  logic                       fill_i,
    input  logic [mem_pkg::ADDR_W-1:0] fill_addr_i,
    input  mem_pkg::line_u             fill_line_i,
    input  logic                       merge_i,
    input  mem_pkg::mem_wr_t           merge_i_data_i
);

    localparam int OFF_W = mem_pkg::OFFSET_W;
    localparam int IDX_W = mem_pkg::INDEX_W;

    logic [mem_pkg::NUM_LINES-1:0] valid_q;
    logic [mem_pkg::TAG_W-1:0]     tag_q  [mem_pkg::NUM_LINES];
    mem_pkg::line_u                line_q [mem_pkg::NUM_LINES];

    logic [IDX_W-1:0]          lk_idx, fill_idx, mg_idx;
    logic [mem_pkg::TAG_W-1:0] lk_tag, fill_tag, mg_tag;
    logic [OFF_W-1:0]          mg_off;
    logic                      mg_hit;
    logic [2:0]                mg_bytes;
    mem_pkg::line_u            mg_line;

    assign {lk_tag, lk_idx}     = lookup_addr_i[mem_pkg::ADDR_W-1:OFF_W];
    assign {fill_tag, fill_idx} = fill_addr_i[mem_pkg::ADDR_W-1:OFF_W];
    assign {mg_tag, mg_idx}     = merge_i_data_i.addr[mem_pkg::ADDR_W-1:OFF_W];
    assign mg_off               = merge_i_data_i.addr[OFF_W-1:0];

    assign hit_o  = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
    assign line_o = line_q[lk_idx];

    // no write allocate, so a store that misses leaves the array untouched.
    assign mg_hit   = valid_q[mg_idx] && (tag_q[mg_idx] == mg_tag);
    assign mg_bytes = mem_pkg::access_bytes(merge_i_data_i.dtype);

    always_comb begin
        mg_line = line_q[mg_idx];
        for (int i = 0; i < 4; i++) begin
            if (3'(i) < mg_bytes) begin
                mg_line.bytes[mg_off + OFF_W'(i)] = merge_i_data_i.wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[fill_idx]  <= fill_tag;
            line_q[fill_idx] <= fill_line_i;
        end else if (merge_i && mg_hit) begin
            line_q[mg_idx] <= mg_line;
        end
    end

endmodule

// File: load_align.sv
`timescale 1ns/1ps

module load_align (
    input  mem_pkg::line_u               line_i,
    input  logic [mem_pkg::OFFSET_W-1:0] offset_i,
    input  mem_pkg::data_type_e          dtype_i,
    input  logic                         is_unsigned_i,
    output logic [mem_pkg::WORD_W-1:0]   data_o
);

    localparam int W = mem_pkg::WORD_W;

    logic [7:0]   sel_byte;
    logic [15:0]  sel_half;
    logic [W-1:0] sel_word;

    // accesses are aligned, so the low offset bits of a half or word are zero.
    assign sel_word = line_i.words[offset_i[mem_pkg::OFFSET_W-1:2]];
    assign sel_byte = line_i.bytes[offset_i];
    assign sel_half = {line_i.bytes[{offset_i[mem_pkg::OFFSET_W-1:1], 1'b1}],
                       line_i.bytes[{offset_i[mem_pkg::OFFSET_W-1:1], 1'b0}]};

    always_comb begin
        case (dtype_i)
            mem_pkg::BYTE: begin
                if (is_unsigned_i) begin
                    data_o = {{(W-8){1'b0}}, sel_byte};
                end else begin
                    data_o = {{(W-8){sel_byte[7]}}, sel_byte};
                end
            end
            mem_pkg::HALF: begin
                if (is_unsigned_i) begin
                    data_o = {{(W-16){1'b0}}, sel_half};
                end else begin
                    data_o = {{(W-16){sel_half[15]}}, sel_half};
                end
            end
            default: data_o = sel_word;
        endcase
    end

endmodule

// File: dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       req_valid_i,
    input  mem_pkg::core_req_t         req_i,
    output logic                       busy_o,
    output logic                       rdata_valid_o,
    output logic [mem_pkg::WORD_W-1:0] rdata_o,
    output logic                       store_done_o,
    output logic                       mem_rd_o,
    output logic [mem_pkg::ADDR_W-1:0] mem_rd_addr_o,
    output logic                       mem_wr_o,
    output mem_pkg::mem_wr_t           mem_wr_data_o,
    input  logic                       mem_rdy_i,
    input  mem_pkg::line_u             mem_line_i
);

    typedef enum logic {
        IDLE,
        MISS_WAIT
    } state_e;

    state_e             state_q;
    logic               valid_q;
    mem_pkg::core_req_t req_q;
    logic               fill_q;
    mem_pkg::line_u     fill_line_q;

    logic           hit;
    logic           load_miss;
    logic           store_now;
    mem_pkg::line_u array_line;
    mem_pkg::line_u resp_line;

    assign load_miss = valid_q && !req_q.is_store && !hit;
    assign store_now = valid_q && req_q.is_store;
    assign busy_o    = load_miss || (state_q == MISS_WAIT);

    // the registered request is held through a miss, since busy blocks new ones.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            valid_q <= 1'b0;
            fill_q  <= 1'b0;
        end else begin
            valid_q <= req_valid_i && !busy_o;
            fill_q  <= (state_q == MISS_WAIT) && mem_rdy_i;
            case (state_q)
                IDLE:      if (load_miss) state_q <= MISS_WAIT;
                MISS_WAIT: if (mem_rdy_i) state_q <= IDLE;
                default:   state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && !busy_o) begin
            req_q <= req_i;
        end
        if (mem_rdy_i) begin
            fill_line_q <= mem_line_i;
        end
    end

    assign mem_rd_o      = load_miss;
    assign mem_rd_addr_o = {req_q.addr[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W],
                            {mem_pkg::OFFSET_W{1'b0}}};

    // every store is written through, hit or miss.
    assign mem_wr_o = store_now;
    always_comb begin
        mem_wr_data_o.dtype = req_q.dtype;
        mem_wr_data_o.addr  = req_q.addr;
        mem_wr_data_o.wdata = req_q.wdata;
    end

    assign store_done_o  = store_now;
    assign rdata_valid_o = (valid_q && !req_q.is_store && hit) || fill_q;
    assign resp_line     = fill_q ? fill_line_q : array_line;

    dcache_array u_array (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .lookup_addr_i  (req_q.addr),
        .hit_o          (hit),
        .line_o         (array_line),
        .fill_i         (fill_q),
        .fill_addr_i    (req_q.addr),
        .fill_line_i    (fill_line_q),
        .merge_i        (store_now),
        .merge_i_data_i (mem_wr_data_o)
    );

    load_align u_align (
        .line_i        (resp_line),
        .offset_i      (req_q.addr[mem_pkg::OFFSET_W-1:0]),
        .dtype_i       (req_q.dtype),
        .is_unsigned_i (req_q.is_unsigned),
        .data_o        (rdata_o)
    );

endmodule

// File: mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       req_valid_i,
    input  mem_pkg::core_req_t         req_i,
    output logic                       busy_o,
    output logic                       rdata_valid_o,
    output logic [mem_pkg::WORD_W-1:0] rdata_o,
    output logic                       store_done_o
);

    logic                       mem_rd;
    logic [mem_pkg::ADDR_W-1:0] mem_rd_addr;
    logic                       mem_wr;
    mem_pkg::mem_wr_t           mem_wr_data;
    logic                       mem_rdy;
    mem_pkg::line_u             mem_line;

    dcache_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .busy_o        (busy_o),
        .rdata_valid_o (rdata_valid_o),
        .rdata_o       (rdata_o),
        .store_done_o  (store_done_o),
        .mem_rd_o      (mem_rd),
        .mem_rd_addr_o (mem_rd_addr),
        .mem_wr_o      (mem_wr),
        .mem_wr_data_o (mem_wr_data),
        .mem_rdy_i     (mem_rdy),
        .mem_line_i    (mem_line)
    );

    main_memory u_mem (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rd_i        (mem_rd),
        .rd_addr_i   (mem_rd_addr),
        .wr_i        (mem_wr),
        .wr_i_data_i (mem_wr_data),
        .data_rdy_o  (mem_rdy),
        .data_o      (mem_line)
    );

endmodule

// File: mem_subsys_sva.sv
`timescale 1ns/1ps

module mem_subsys_sva (
    input logic clk_i,
    input logic rst_n_i,
    input logic req_valid_i,
    input logic busy_o,
    input logic rdata_valid_o,
    input logic store_done_o
);

    int err_cnt = 0;

    busy_low_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !busy_o)
        else begin
            err_cnt++;
            $error("busy_o is high in the first cycle after reset");
        end

    // every response is a single-cycle pulse.
    rdata_valid_single: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) rdata_valid_o |=> !rdata_valid_o)
        else begin
            err_cnt++;
            $error("rdata_valid_o stayed high for two cycles");
        end

    store_done_single: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) store_done_o |=> !store_done_o)
        else begin
            err_cnt++;
            $error("store_done_o stayed high for two cycles");
        end

    no_req_while_busy: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) busy_o |-> !req_valid_i)
        else begin
            err_cnt++;
            $error("the core made a request while busy_o was high");
        end

endmodule

bind dcache_ctrl mem_subsys_sva u_sva (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .busy_o        (busy_o),
    .rdata_valid_o (rdata_valid_o),
    .store_done_o  (store_done_o)
);

// File: tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int RESET_CYCLES = 16;
    localparam int MISS_CYCLES  = 12;
    // about 180 accesses of at most 14 cycles each, with a margin of two.
    localparam int TIMEOUT_CYCLES = 2 * 180 * 14;

    logic                       clk_i;
    logic                       rst_n_i;
    logic                       req_valid_i;
    mem_pkg::core_req_t         req_i;
    logic                       busy_o;
    logic                       rdata_valid_o;
    logic [mem_pkg::WORD_W-1:0] rdata_o;
    logic                       store_done_o;

    logic [7:0] ref_mem [mem_pkg::MEM_BYTES];
    int         cycle_cnt = 0;
    int         cycles;

    mem_subsys dut_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .busy_o        (busy_o),
        .rdata_valid_o (rdata_valid_o),
        .rdata_o       (rdata_o),
        .store_done_o  (store_done_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, the DUT gave no result within %0d cycles", cycle_cnt);
            $display("test failed");
            $fatal(1, "run ended on timeout");
        end
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "run ended on a mismatch");
        end
    endtask

    // little-endian read of the reference bytes, then sign or zero extension.
    function automatic logic [31:0] expected_load(input logic [15:0] addr,
                                                  input mem_pkg::data_type_e dtype,
                                                  input logic uns);
        logic [31:0] raw;
        raw = {ref_mem[16'(addr + 16'd3)], ref_mem[16'(addr + 16'd2)],
               ref_mem[16'(addr + 16'd1)], ref_mem[addr]};
        case (dtype)
            mem_pkg::BYTE: return uns ? {24'h0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
            mem_pkg::HALF: return uns ? {16'h0, raw[15:0]} : {{16{raw[15]}}, raw[15:0]};
            default:       return raw;
        endcase
    endfunction

    task automatic access(input logic st, input mem_pkg::data_type_e dtype, input logic uns,
                          input logic [15:0] addr, input logic [31:0] wdata);
        mem_pkg::core_req_t req;
        int                 nbytes;
        req.is_store    = st;
        req.dtype       = dtype;
        req.is_unsigned = uns;
        req.addr        = addr;
        req.wdata       = wdata;
        nbytes = (dtype == mem_pkg::BYTE) ? 1 : ((dtype == mem_pkg::HALF) ? 2 : 4);
        @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_i       <= req;
        @(posedge clk_i);
        req_valid_i <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
            // until the response the core must be held off.
            if (!rdata_valid_o && !store_done_o) begin
                check("busy_o while waiting", 32'(busy_o), 32'd1);
            end
        end while (!rdata_valid_o && !store_done_o);
        if (st) begin
            check("store_done_o", 32'(store_done_o), 32'd1);
            check("store cycles", 32'(cycles), 32'd1);
            for (int i = 0; i < nbytes; i++) begin
                ref_mem[16'(addr + 16'(i))] = wdata[8*i +: 8];
            end
        end else begin
            check("rdata_valid_o", 32'(rdata_valid_o), 32'd1);
            check($sformatf("load at %h", addr), rdata_o, expected_load(addr, dtype, uns));
        end
    endtask

    task automatic word_store_load();
        access(1'b1, mem_pkg::WORD, 1'b0, 16'h0040, 32'hdead_beef);
        access(1'b0, mem_pkg::WORD, 1'b0, 16'h0040, 32'h0);
        check("first load cycles", 32'(cycles), 32'(MISS_CYCLES));
        access(1'b0, mem_pkg::WORD, 1'b0, 16'h0040, 32'h0);
        check("second load cycles", 32'(cycles), 32'd1);
    endtask

    task automatic subword_access();
        access(1'b1, mem_pkg::WORD, 1'b0, 16'h0100, 32'h1234_5678);
        access(1'b0, mem_pkg::WORD, 1'b0, 16'h0100, 32'h0);
        access(1'b1, mem_pkg::BYTE, 1'b0, 16'h0101, 32'h0000_009a);
        access(1'b1, mem_pkg::HALF, 1'b0, 16'h0102, 32'h0000_8001);
        for (int u = 0; u < 2; u++) begin
            for (int off = 0; off < 4; off++) begin
                access(1'b0, mem_pkg::BYTE, 1'(u), 16'(16'h0100 + off), 32'h0);
            end
            access(1'b0, mem_pkg::HALF, 1'(u), 16'h0100, 32'h0);
            access(1'b0, mem_pkg::HALF, 1'(u), 16'h0102, 32'h0);
        end
        access(1'b0, mem_pkg::WORD, 1'b0, 16'h0100, 32'h0);
        access(1'b0, mem_pkg::BYTE, 1'b0, 16'h0101, 32'h0);
        check("signed byte load", rdata_o, 32'hffff_ff9a);
    endtask

    task automatic miss_latency();
        access(1'b0, mem_pkg::WORD, 1'b0, 16'h0a80, 32'h0);
        check("miss cycles", 32'(cycles), 32'(MISS_CYCLES));
        access(1'b0, mem_pkg::HALF, 1'b1, 16'h0a86, 32'h0);
        check("reload cycles", 32'(cycles), 32'd1);
    endtask

    // both addresses map to index 3, so each load evicts the other line.
    task automatic conflict_write_through();
        access(1'b1, mem_pkg::WORD, 1'b0, 16'h1230, 32'hcafe_0123);
        access(1'b1, mem_pkg::WORD, 1'b0, 16'h2234, 32'h5a5a_a5a5);
        for (int n = 0; n < 2; n++) begin
            access(1'b0, mem_pkg::WORD, 1'b0, 16'h1230, 32'h0);
            check("conflict load cycles", 32'(cycles), 32'(MISS_CYCLES));
            access(1'b0, mem_pkg::WORD, 1'b0, 16'h2234, 32'h0);
            check("conflict load cycles", 32'(cycles), 32'(MISS_CYCLES));
        end
    endtask

    task automatic random_mix();
        logic [15:0]         addr;
        mem_pkg::data_type_e dtype;
        for (int n = 0; n < 150; n++) begin
            addr = 16'h0400 | 16'($urandom % 256);
            case ($urandom % 3)
                0:       dtype = mem_pkg::BYTE;
                1:       dtype = mem_pkg::HALF;
                default: dtype = mem_pkg::WORD;
            endcase
            if (dtype == mem_pkg::HALF) begin
                addr[0] = 1'b0;
            end else if (dtype == mem_pkg::WORD) begin
                addr[1:0] = 2'b00;
            end
            access(1'($urandom % 2), dtype, 1'($urandom % 2), addr, $urandom);
        end
    endtask

    initial begin
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        for (int a = 0; a < mem_pkg::MEM_BYTES; a++) begin
            ref_mem[a] = 8'h00;
        end
        void'($urandom(24179));
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        word_store_load();
        subword_access();
        miss_latency();
        conflict_write_through();
        random_mix();
        if (dut_i.u_ctrl.u_sva.err_cnt != 0) begin
            $display("a core-side protocol assertion failed during the run");
            $display("test failed");
            $fatal(1, "run ended on an assertion failure");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// File: tb.f
mem_pkg.sv
main_memory.sv
dcache_array.sv
load_align.sv
dcache_ctrl.sv
mem_subsys.sv
mem_subsys_sva.sv
tb_mem_subsys.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := tb_mem_subsys
FILELIST  := tb.f
OBJ_DIR   := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
